/* design/pll_reconfig_pkg.sv */
package pll_reconfig_pkg;

	////////////////////////////////////////
	// Widths and sizes

	// DRP bus widths of the MMCM
	localparam int DRP_ADDR_W = 7;
	localparam int DRP_DATA_W = 16;

	// Pending write slots, also the starting credit count
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	// Holds 0 through QUEUE_DEPTH
	localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);

	// CLKOUT0 through CLKOUT5
	localparam int NUM_OUTPUTS = 6;

	////////////////////////////////////////
	// DRP register map

	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT5_CLKREG1 = 7'h06;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT5_CLKREG2 = 7'h07;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT0_CLKREG1 = 7'h08;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT0_CLKREG2 = 7'h09;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT1_CLKREG1 = 7'h0a;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT1_CLKREG2 = 7'h0b;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT2_CLKREG1 = 7'h0c;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT2_CLKREG2 = 7'h0d;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT3_CLKREG1 = 7'h0e;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT3_CLKREG2 = 7'h0f;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT4_CLKREG1 = 7'h10;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKOUT4_CLKREG2 = 7'h11;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKFBOUT_CLKREG1 = 7'h14;
	localparam logic [DRP_ADDR_W-1:0] REG_CLKFBOUT_CLKREG2 = 7'h15;
	localparam logic [DRP_ADDR_W-1:0] REG_INDIV = 7'h16;
	localparam logic [DRP_ADDR_W-1:0] REG_POWER_CONFIG = 7'h28;

	// Keep-masks, a set bit preserves the old register bit
	localparam logic [DRP_DATA_W-1:0] MASK_RESERVED_CLKREG1 = 16'h1000;
	localparam logic [DRP_DATA_W-1:0] MASK_CLKREG2_OUT0_FB = 16'h8000;
	localparam logic [DRP_DATA_W-1:0] MASK_CLKREG2_OUT1_4 = 16'hfc00;
	localparam logic [DRP_DATA_W-1:0] MASK_CLKREG2_OUT5 = 16'hc000;
	localparam logic [DRP_DATA_W-1:0] MASK_INDIV = 16'hc000;

	////////////////////////////////////////
	// Bundled signal types

	// VCO command from the host
	typedef struct packed {
		logic en;
		logic [6:0] mult;
		logic [6:0] indiv;
	} vco_cmd_t;

	// Output divider command, phase in eighths of a VCO period
	typedef struct packed {
		logic en;
		logic [2:0] idx;
		logic [7:0] div;
		logic [8:0] phase;
	} output_cmd_t;

	// One masked register write waiting for the engine
	typedef struct packed {
		logic [DRP_ADDR_W-1:0] addr;
		logic [DRP_DATA_W-1:0] wdata;
		logic [DRP_DATA_W-1:0] wmask;
	} reg_write_t;

	// DRP master request
	typedef struct packed {
		logic en;
		logic we;
		logic [DRP_ADDR_W-1:0] addr;
		logic [DRP_DATA_W-1:0] din;
	} drp_req_t;

endpackage

/* design/pll_reconfig_sequencer.sv */
`timescale 1ns/1ns

module pll_reconfig_sequencer (
	input logic reconfig_clk,
	input logic reset,
	input logic reconfig_start,
	input logic reconfig_finish,
	input logic pll_reset_req,
	input pll_reconfig_pkg::vco_cmd_t vco_cmd,
	input pll_reconfig_pkg::output_cmd_t output_cmd,
	input logic write_done,
	output logic push,
	output pll_reconfig_pkg::reg_write_t push_req,
	output logic busy,
	output logic reconfig_cmd_done,
	output logic pll_reset
);

	typedef enum logic [2:0] {
		BOOT_HOLD,
		IDLE,
		READY,
		ISSUE,
		WAIT_CREDITS
	} state_t;

	state_t state;

	// Free queue slots plus the engine slot
	logic [pll_reconfig_pkg::COUNT_W-1:0] credits;
	logic credits_home;
	logic push_now;
	logic boot_sent;

	// Latched command and position in its write list
	pll_reconfig_pkg::vco_cmd_t vco_lat;
	pll_reconfig_pkg::output_cmd_t out_lat;
	logic cmd_vco;
	logic [1:0] step;
	logic [1:0] last_step;

	// Per-output register selection
	logic [pll_reconfig_pkg::DRP_ADDR_W-1:0] out_reg1;
	logic [pll_reconfig_pkg::DRP_ADDR_W-1:0] out_reg2;
	logic [pll_reconfig_pkg::DRP_DATA_W-1:0] out_mask2;
	pll_reconfig_pkg::reg_write_t next_write;

	// High time in the upper six bits, low time in the lower six
	// Odd values get the extra VCO cycle on the low side
	function automatic logic [11:0] divider_times(input logic [6:0] value);
		logic [5:0] half;
		half = value[6:1];
		return {half, half + {5'd0, value[0]}};
	endfunction

	assign credits_home = (credits == pll_reconfig_pkg::COUNT_W'(pll_reconfig_pkg::QUEUE_DEPTH));
	assign last_step = cmd_vco ? 2'd2 : 2'd1;

	// A push spends a credit, the boot write included
	assign push_now = (credits != '0) &&
		((state == BOOT_HOLD && !boot_sent) || state == ISSUE);

	////////////////////////////////////////
	// Output register lookup

	always_comb begin
		out_reg1 = pll_reconfig_pkg::REG_CLKOUT0_CLKREG1;
		out_reg2 = pll_reconfig_pkg::REG_CLKOUT0_CLKREG2;
		out_mask2 = pll_reconfig_pkg::MASK_CLKREG2_OUT0_FB;
		case (out_lat.idx)
			3'd1: begin
				out_reg1 = pll_reconfig_pkg::REG_CLKOUT1_CLKREG1;
				out_reg2 = pll_reconfig_pkg::REG_CLKOUT1_CLKREG2;
				out_mask2 = pll_reconfig_pkg::MASK_CLKREG2_OUT1_4;
			end
			3'd2: begin
				out_reg1 = pll_reconfig_pkg::REG_CLKOUT2_CLKREG1;
				out_reg2 = pll_reconfig_pkg::REG_CLKOUT2_CLKREG2;
				out_mask2 = pll_reconfig_pkg::MASK_CLKREG2_OUT1_4;
			end
			3'd3: begin
				out_reg1 = pll_reconfig_pkg::REG_CLKOUT3_CLKREG1;
				out_reg2 = pll_reconfig_pkg::REG_CLKOUT3_CLKREG2;
				out_mask2 = pll_reconfig_pkg::MASK_CLKREG2_OUT1_4;
			end
			3'd4: begin
				out_reg1 = pll_reconfig_pkg::REG_CLKOUT4_CLKREG1;
				out_reg2 = pll_reconfig_pkg::REG_CLKOUT4_CLKREG2;
				out_mask2 = pll_reconfig_pkg::MASK_CLKREG2_OUT1_4;
			end
			// CLKOUT5 keeps its two upper bits
			3'd5: begin
				out_reg1 = pll_reconfig_pkg::REG_CLKOUT5_CLKREG1;
				out_reg2 = pll_reconfig_pkg::REG_CLKOUT5_CLKREG2;
				out_mask2 = pll_reconfig_pkg::MASK_CLKREG2_OUT5;
			end
			default: begin
			end
		endcase
	end

	////////////////////////////////////////
	// Write builder for the current step

	always_comb begin
		next_write = '0;
		if (cmd_vco) begin
			case (step)
				// Feedback counter high and low times
				2'd0: begin
					next_write.addr = pll_reconfig_pkg::REG_CLKFBOUT_CLKREG1;
					next_write.wmask = pll_reconfig_pkg::MASK_RESERVED_CLKREG1;
					next_write.wdata[11:0] = divider_times(vco_lat.mult);
				end
				// Edge and no-count, no feedback phase
				2'd1: begin
					next_write.addr = pll_reconfig_pkg::REG_CLKFBOUT_CLKREG2;
					next_write.wmask = pll_reconfig_pkg::MASK_CLKREG2_OUT0_FB;
					next_write.wdata[7] = vco_lat.mult[0];
					next_write.wdata[6] = (vco_lat.mult == 7'd1);
				end
				default: begin
					next_write.addr = pll_reconfig_pkg::REG_INDIV;
					next_write.wmask = pll_reconfig_pkg::MASK_INDIV;
					next_write.wdata[13] = vco_lat.indiv[0];
					next_write.wdata[12] = (vco_lat.indiv == 7'd1);
					next_write.wdata[11:0] = divider_times(vco_lat.indiv);
				end
			endcase
		end else if (step == 2'd0) begin
			// Same clkreg1 layout on every output
			next_write.addr = out_reg1;
			next_write.wmask = pll_reconfig_pkg::MASK_RESERVED_CLKREG1;
			next_write.wdata[15:13] = out_lat.phase[2:0];
			next_write.wdata[11:0] = divider_times(out_lat.div[6:0]);
		end else begin
			next_write.addr = out_reg2;
			next_write.wmask = out_mask2;
			next_write.wdata[7] = out_lat.div[0];
			next_write.wdata[6] = (out_lat.div == 8'd1);
			// Whole-period phase part
			next_write.wdata[5:0] = out_lat.phase[8:3];
		end
	end

	////////////////////////////////////////
	// Mode FSM

	always_ff @(posedge reconfig_clk) begin
		if (reset) begin
			state <= BOOT_HOLD;
			credits <= pll_reconfig_pkg::COUNT_W'(pll_reconfig_pkg::QUEUE_DEPTH);
			boot_sent <= 1'b0;
			busy <= 1'b1;
			pll_reset <= 1'b1;
			reconfig_cmd_done <= 1'b0;
			push <= 1'b0;
			cmd_vco <= 1'b0;
			step <= 2'd0;
		end else begin
			push <= 1'b0;
			reconfig_cmd_done <= 1'b0;

			// Spend on push, refund on each finished DRP write
			credits <= credits - pll_reconfig_pkg::COUNT_W'(push_now)
				+ pll_reconfig_pkg::COUNT_W'(write_done);

			// First write to finish is the power write
			if (write_done)
				busy <= 1'b0;

			case (state)
				BOOT_HOLD: begin
					// Power up every block of the primitive
					if (!boot_sent) begin
						push <= 1'b1;
						push_req <= pll_reconfig_pkg::reg_write_t'{
							addr: pll_reconfig_pkg::REG_POWER_CONFIG,
							wdata: '1,
							wmask: '0
						};
						boot_sent <= 1'b1;
					end else if (reconfig_start) begin
						state <= READY;
						pll_reset <= 1'b1;
					end else if (pll_reset_req) begin
						state <= IDLE;
					end
				end

				IDLE: begin
					// Reset request becomes a single PLL reset cycle
					pll_reset <= pll_reset_req;
					if (reconfig_start) begin
						pll_reset <= 1'b1;
						state <= READY;
					end
				end

				READY: begin
					if (reconfig_finish) begin
						state <= IDLE;
					end else if (credits_home && vco_cmd.en) begin
						vco_lat <= vco_cmd;
						cmd_vco <= 1'b1;
						step <= 2'd0;
						state <= ISSUE;
					end else if (credits_home && output_cmd.en) begin
						out_lat <= output_cmd;
						cmd_vco <= 1'b0;
						step <= 2'd0;
						// Unknown output index completes with no writes
						if (output_cmd.idx < pll_reconfig_pkg::NUM_OUTPUTS)
							state <= ISSUE;
						else
							state <= WAIT_CREDITS;
					end
				end

				// Stalls here while out of credit
				ISSUE: begin
					if (push_now) begin
						push <= 1'b1;
						push_req <= next_write;
						if (step == last_step)
							state <= WAIT_CREDITS;
						else
							step <= step + 2'd1;
					end
				end

				// All writes of the command landed in the DRP
				WAIT_CREDITS: begin
					if (credits_home) begin
						reconfig_cmd_done <= 1'b1;
						state <= READY;
					end
				end

				default: state <= BOOT_HOLD;
			endcase
		end
	end

endmodule

/* design/drp_write_queue.sv */
`timescale 1ns/1ns

module drp_write_queue (
	input logic reconfig_clk,
	input logic reset,
	input logic push,
	input pll_reconfig_pkg::reg_write_t push_req,
	input logic pop,
	output logic head_valid,
	output pll_reconfig_pkg::reg_write_t head_req
);

	// Entry storage
	pll_reconfig_pkg::reg_write_t mem [pll_reconfig_pkg::QUEUE_DEPTH];

	logic [pll_reconfig_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [pll_reconfig_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [pll_reconfig_pkg::COUNT_W-1:0] count;

	// Wrap back to slot zero after the last one
	function automatic logic [pll_reconfig_pkg::QUEUE_PTR_W-1:0] ptr_next(
		input logic [pll_reconfig_pkg::QUEUE_PTR_W-1:0] ptr
	);
		if (ptr == pll_reconfig_pkg::QUEUE_PTR_W'(pll_reconfig_pkg::QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign head_req = mem[rd_ptr];

	always_ff @(posedge reconfig_clk) begin
		if (push)
			mem[wr_ptr] <= push_req;
	end

	////////////////////////////////////////
	// Pointers and occupancy

	// No overflow check, the sequencer credits cap the fill level
	always_ff @(posedge reconfig_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);

			// Simultaneous push and pop leaves the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

/* design/drp_rmw_engine.sv */
`timescale 1ns/1ns

module drp_rmw_engine (
	input logic reconfig_clk,
	input logic reset,
	input logic head_valid,
	input pll_reconfig_pkg::reg_write_t head_req,
	input logic [pll_reconfig_pkg::DRP_DATA_W-1:0] drp_dout,
	input logic drp_ready,
	output logic pop,
	output pll_reconfig_pkg::drp_req_t drp_req,
	output logic write_done
);

	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE
	} state_t;

	state_t state;

	// Request in progress
	pll_reconfig_pkg::reg_write_t cur_req;

	// Take the head whenever nothing is outstanding
	assign pop = (state == IDLE) && head_valid;

	////////////////////////////////////////
	// Read-modify-write FSM

	always_ff @(posedge reconfig_clk) begin
		if (reset) begin
			state <= IDLE;
			drp_req.en <= 1'b0;
			drp_req.we <= 1'b0;
			write_done <= 1'b0;
		end else begin
			// Strobes last one cycle
			drp_req.en <= 1'b0;
			drp_req.we <= 1'b0;
			write_done <= 1'b0;

			case (state)
				// Start with a read of the target register
				IDLE: begin
					if (pop) begin
						cur_req <= head_req;
						drp_req.en <= 1'b1;
						drp_req.addr <= head_req.addr;
						state <= READ;
					end
				end

				// Old bits under the mask, new bits elsewhere
				READ: begin
					if (drp_ready) begin
						drp_req.en <= 1'b1;
						drp_req.we <= 1'b1;
						drp_req.addr <= cur_req.addr;
						drp_req.din <= (drp_dout & cur_req.wmask) |
							(cur_req.wdata & ~cur_req.wmask);
						state <= WRITE;
					end
				end

				// Write acknowledged, hand a credit back
				WRITE: begin
					if (drp_ready) begin
						write_done <= 1'b1;
						state <= IDLE;
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* design/pll_reconfig_top.sv */
`timescale 1ns/1ns

module pll_reconfig_top (
	input logic reconfig_clk,
	input logic reset,

	// Host control
	input logic reconfig_start,
	input logic reconfig_finish,
	input logic pll_reset_req,
	input pll_reconfig_pkg::vco_cmd_t vco_cmd,
	input pll_reconfig_pkg::output_cmd_t output_cmd,
	output logic busy,
	output logic reconfig_cmd_done,
	output logic pll_reset,

	// DRP master toward the MMCM
	input logic [pll_reconfig_pkg::DRP_DATA_W-1:0] drp_dout,
	input logic drp_ready,
	output pll_reconfig_pkg::drp_req_t drp_req
);

	////////////////////////////////////////
	// Internal links

	// Sequencer into queue
	logic push;
	pll_reconfig_pkg::reg_write_t push_req;

	// Queue head into engine
	logic pop;
	logic head_valid;
	pll_reconfig_pkg::reg_write_t head_req;

	// Credit return
	logic write_done;

	pll_reconfig_sequencer i_sequencer (
		.reconfig_clk(reconfig_clk),
		.reset(reset),
		.reconfig_start(reconfig_start),
		.reconfig_finish(reconfig_finish),
		.pll_reset_req(pll_reset_req),
		.vco_cmd(vco_cmd),
		.output_cmd(output_cmd),
		.write_done(write_done),
		.push(push),
		.push_req(push_req),
		.busy(busy),
		.reconfig_cmd_done(reconfig_cmd_done),
		.pll_reset(pll_reset)
	);

	drp_write_queue i_queue (
		.reconfig_clk(reconfig_clk),
		.reset(reset),
		.push(push),
		.push_req(push_req),
		.pop(pop),
		.head_valid(head_valid),
		.head_req(head_req)
	);

	drp_rmw_engine i_engine (
		.reconfig_clk(reconfig_clk),
		.reset(reset),
		.head_valid(head_valid),
		.head_req(head_req),
		.drp_dout(drp_dout),
		.drp_ready(drp_ready),
		.pop(pop),
		.drp_req(drp_req),
		.write_done(write_done)
	);

endmodule

/* verification/pll_reconfig_checker.sv */
`timescale 1ns/1ns

module pll_reconfig_checker (
	input logic reconfig_clk,
	input logic reset,
	input pll_reconfig_pkg::drp_req_t drp_req,
	input logic drp_ready,
	input logic reconfig_cmd_done,
	input logic busy,
	input logic pll_reset
);

	// Request sent and not yet answered
	logic outstanding;
	// A read went out and its write has not followed yet
	logic read_armed;
	logic [pll_reconfig_pkg::DRP_ADDR_W-1:0] read_addr;
	// Assertion failures so far
	int failures = 0;

	always_ff @(posedge reconfig_clk) begin
		if (reset) begin
			outstanding <= 1'b0;
			read_armed <= 1'b0;
			read_addr <= '0;
		end else begin
			if (drp_req.en)
				outstanding <= 1'b1;
			else if (drp_ready)
				outstanding <= 1'b0;
			if (drp_req.en && !drp_req.we) begin
				read_armed <= 1'b1;
				read_addr <= drp_req.addr;
			end else if (drp_req.en && drp_req.we) begin
				read_armed <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////
	// DRP protocol

	no_early_strobe: assert property (@(posedge reconfig_clk) disable iff (reset)
		drp_req.en |-> !outstanding)
		else begin
			$error("DRP strobe sent before the previous ready");
			failures++;
		end

	read_before_write: assert property (@(posedge reconfig_clk) disable iff (reset)
		(drp_req.en && drp_req.we) |-> (read_armed && drp_req.addr == read_addr))
		else begin
			$error("DRP write without a read of the same address");
			failures++;
		end

	// Commands only finish in reconfiguration mode, with boot over
	done_in_ready: assert property (@(posedge reconfig_clk) disable iff (reset)
		reconfig_cmd_done |-> (pll_reset && !busy))
		else begin
			$error("Command done outside reconfiguration mode");
			failures++;
		end

endmodule

bind pll_reconfig_top pll_reconfig_checker i_checker (
	.reconfig_clk(reconfig_clk),
	.reset(reset),
	.drp_req(drp_req),
	.drp_ready(drp_ready),
	.reconfig_cmd_done(reconfig_cmd_done),
	.busy(busy),
	.pll_reset(pll_reset)
);

/* verification/tb_pll_reconfig.sv */
`timescale 1ns/1ns

module tb_pll_reconfig;

	logic reconfig_clk;
	logic reset;
	logic reconfig_start;
	logic reconfig_finish;
	logic pll_reset_req;
	pll_reconfig_pkg::vco_cmd_t vco_cmd;
	pll_reconfig_pkg::output_cmd_t output_cmd;
	logic busy;
	logic reconfig_cmd_done;
	logic pll_reset;
	logic [15:0] drp_dout;
	logic drp_ready;
	pll_reconfig_pkg::drp_req_t drp_req;

	// MMCM register file and the writes expected on the DRP, in order
	logic [15:0] regfile [128];
	logic [6:0] exp_addr [$];
	logic [15:0] exp_data [$];
	logic [15:0] exp_mask [$];

	// DRP model state
	logic pend;
	logic pend_we;
	logic [6:0] pend_addr;
	int pend_delay;

	int errors;
	int tests_run;
	int tests_failed;
	int err_mark;
	int high_cycles;

	pll_reconfig_top i_dut (.*);

	always #4 reconfig_clk = ~reconfig_clk;

	//////////////////////////////////////////
	// Expected register fields

	// High time above, low time below; odd values get the extra low cycle
	function automatic logic [11:0] div_times(input logic [6:0] v);
		logic [5:0] hi;
		logic [5:0] lo;
		hi = 6'(v >> 1);
		lo = 6'(v >> 1) + 6'(v % 2);
		return {hi, lo};
	endfunction

	// CLKOUT5 sits below CLKOUT0 in the map
	function automatic logic [6:0] out_addr(input int idx, input int second);
		if (idx == 5)
			return 7'(6 + second);
		return 7'(8 + 2 * idx + second);
	endfunction

	function automatic logic [15:0] out_mask2(input int idx);
		if (idx == 0)
			return 16'h8000;
		if (idx == 5)
			return 16'hc000;
		return 16'hfc00;
	endfunction

	task automatic expect_write(input logic [6:0] a, input logic [15:0] d,
		input logic [15:0] m);
		exp_addr.push_back(a);
		exp_data.push_back(d);
		exp_mask.push_back(m);
	endtask

	//////////////////////////////////////////
	// DRP register-file model

	always @(negedge reconfig_clk) begin
		logic [15:0] want;
		drp_ready = 1'b0;
		if (reset) begin
			pend = 1'b0;
		end else begin
			// Answer an outstanding request once its delay runs out
			if (pend) begin
				if (pend_delay == 0) begin
					drp_ready = 1'b1;
					pend = 1'b0;
					if (!pend_we)
						drp_dout = regfile[pend_addr];
				end else begin
					pend_delay--;
				end
			end
			if (drp_req.en) begin
				pend = 1'b1;
				pend_we = drp_req.we;
				pend_addr = drp_req.addr;
				pend_delay = $urandom % 4;
				if (drp_req.we) begin
					if (exp_addr.size() == 0) begin
						$display("Unexpected DRP write to address %h at %0t",
							drp_req.addr, $time);
						errors++;
					end else begin
						// Old bits kept under the mask, command bits elsewhere
						want = (regfile[drp_req.addr] & exp_mask[0]) |
							(exp_data[0] & ~exp_mask[0]);
						assert (drp_req.addr == exp_addr[0]) else begin
							$display("CHECK FAILED at %0t: drp_req.addr got %h expected %h",
								$time, drp_req.addr, exp_addr[0]);
							errors++;
						end
						assert (drp_req.din == want) else begin
							$display("CHECK FAILED at %0t: drp_req.din got %h expected %h",
								$time, drp_req.din, want);
							errors++;
						end
						void'(exp_addr.pop_front());
						void'(exp_data.pop_front());
						void'(exp_mask.pop_front());
					end
					regfile[drp_req.addr] = drp_req.din;
				end
			end
		end
	end

	//////////////////////////////////////////
	// Waits and small helpers

	task automatic wait_busy_low();
		int i;
		for (i = 0; i < 200 && busy; i++)
			@(negedge reconfig_clk);
		if (busy) begin
			$display("Timeout waiting for busy to fall");
			errors++;
		end
	endtask

	task automatic wait_cmd_done(input string what);
		int i;
		for (i = 0; i < 500 && !reconfig_cmd_done; i++)
			@(negedge reconfig_clk);
		if (!reconfig_cmd_done) begin
			$display("Timeout waiting for the %s command to finish", what);
			errors++;
		end
		@(negedge reconfig_clk);
		assert (exp_addr.size() == 0) else begin
			$display("CHECK FAILED at %0t: pending writes got %0d expected 0",
				$time, exp_addr.size());
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		assert (got == want) else begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic begin_test();
		err_mark = errors;
		tests_run++;
	endtask

	task automatic end_test(input string name);
		if (errors != err_mark) begin
			tests_failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// Count pll_reset high cycles over a short window, current cycle first
	task automatic count_pll_reset(input int window);
		high_cycles = 0;
		repeat (window) begin
			if (pll_reset)
				high_cycles++;
			@(negedge reconfig_clk);
		end
	endtask

	//////////////////////////////////////////
	// Stimulus

	initial begin
		logic [6:0] mult;
		logic [6:0] indiv;
		logic [7:0] div;
		logic [8:0] phase;
		void'($urandom(32'h653b));
		for (int a = 0; a < 128; a++)
			regfile[a] = 16'($urandom);
		reconfig_clk = 1'b0;
		reset = 1'b1;
		reconfig_start = 1'b0;
		reconfig_finish = 1'b0;
		pll_reset_req = 1'b0;
		vco_cmd = '0;
		output_cmd = '0;
		drp_dout = '0;
		drp_ready = 1'b0;
		pend = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;

		// Boot power write
		begin_test();
		expect_write(7'h28, 16'hffff, 16'h0000);
		repeat (3) @(negedge reconfig_clk);
		reset = 1'b0;
		@(negedge reconfig_clk);
		check_bit("busy", busy, 1'b1);
		wait_busy_low();
		check_bit("pll_reset", pll_reset, 1'b1);
		assert (exp_addr.size() == 0) else begin
			$display("Boot power write never reached the DRP");
			errors++;
		end
		end_test("boot");

		// Modes, first reset request leaves BOOT_HOLD
		begin_test();
		pll_reset_req = 1'b1;
		@(negedge reconfig_clk);
		pll_reset_req = 1'b0;
		repeat (3) @(negedge reconfig_clk);
		check_bit("pll_reset", pll_reset, 1'b0);
		// Single request in IDLE
		pll_reset_req = 1'b1;
		@(negedge reconfig_clk);
		pll_reset_req = 1'b0;
		count_pll_reset(5);
		assert (high_cycles == 1) else begin
			$display("CHECK FAILED at %0t: pll_reset cycles got %0d expected 1",
				$time, high_cycles);
			errors++;
		end
		reconfig_start = 1'b1;
		@(negedge reconfig_clk);
		reconfig_start = 1'b0;
		count_pll_reset(6);
		assert (high_cycles == 6) else begin
			$display("CHECK FAILED at %0t: pll_reset cycles got %0d expected 6",
				$time, high_cycles);
			errors++;
		end
		end_test("modes");

		// VCO command
		begin_test();
		mult = 7'(($urandom % 127) + 1);
		indiv = 7'(($urandom % 127) + 1);
		expect_write(7'h14, {4'h0, div_times(mult)}, 16'h1000);
		expect_write(7'h15, {8'h00, mult[0], mult == 7'd1, 6'd0}, 16'h8000);
		expect_write(7'h16, {2'b00, indiv[0], indiv == 7'd1, div_times(indiv)}, 16'hc000);
		vco_cmd.en = 1'b1;
		vco_cmd.mult = mult;
		vco_cmd.indiv = indiv;
		@(negedge reconfig_clk);
		vco_cmd = '0;
		wait_cmd_done("VCO");
		end_test("vco");

		// Output commands over every index
		for (int idx = 0; idx < 6; idx++) begin
			begin_test();
			div = 8'(($urandom % 127) + 1);
			phase = 9'($urandom);
			expect_write(out_addr(idx, 0), {phase[2:0], 1'b0, div_times(div[6:0])}, 16'h1000);
			expect_write(out_addr(idx, 1), {8'h00, div[0], div == 8'd1, phase[8:3]},
				out_mask2(idx));
			output_cmd.en = 1'b1;
			output_cmd.idx = 3'(idx);
			output_cmd.div = div;
			output_cmd.phase = phase;
			@(negedge reconfig_clk);
			output_cmd = '0;
			wait_cmd_done("output");
			end_test($sformatf("output %0d", idx));
		end

		// Leaving reconfiguration releases the PLL reset
		begin_test();
		check_bit("pll_reset", pll_reset, 1'b1);
		reconfig_finish = 1'b1;
		@(negedge reconfig_clk);
		reconfig_finish = 1'b0;
		repeat (2) @(negedge reconfig_clk);
		check_bit("pll_reset", pll_reset, 1'b0);
		end_test("finish");

		// Protocol assertion failures from the bound checker
		errors += i_dut.i_checker.failures;

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
design/pll_reconfig_pkg.sv
design/pll_reconfig_sequencer.sv
design/drp_write_queue.sv
design/drp_rmw_engine.sv
design/pll_reconfig_top.sv
verification/pll_reconfig_checker.sv
verification/tb_pll_reconfig.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PLL reconfiguration testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_pll_reconfig \
	-f verilog.f \
	-o sim_tb_pll_reconfig
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_pll_reconfig > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0
